/* compile.f */
src/wino_types_pkg.sv
src/wino_ctrl_pkg.sv
src/wino_vec6_if.sv
src/wino_sum_tree.sv
src/wino_row_transform.sv
src/wino_tile_buffer.sv
src/wino_seq_fsm.sv
src/wino_step_counter.sv
src/wino_output_stage.sv
src/wino_inverse_top.sv
tests/tb_wino_inverse.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_wino_inverse
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_wino_inverse > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
	exit 0
fi
echo "no pass line found in $LOG"
exit 1

/* src/wino_ctrl_pkg.sv */
package wino_ctrl_pkg;

	// sequencer states.
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		DRAIN
	} seq_state_t;

	// step count, wide enough for six rows.
	typedef logic [2:0] step_t;

	// rows per tile and columns per result.
	localparam int LOAD_STEPS  = 6;
	localparam int DRAIN_STEPS = 4;

endpackage

/* src/wino_inverse_top.sv */
`timescale 1ns/1ps

module wino_inverse_top import wino_types_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_valid,
	input  acc_t      i_data_0,
	input  acc_t      i_data_1,
	input  acc_t      i_data_2,
	input  acc_t      i_data_3,
	input  acc_t      i_data_4,
	input  acc_t      i_data_5,
	output out_word_t o_result_0,
	output out_word_t o_result_1,
	output out_word_t o_result_2,
	output out_word_t o_result_3,
	output logic      o_valid
);

	wino_vec6_if in_vec ();
	wino_vec6_if col_vec ();

	acc_t      row_res [4];
	acc_t      col_res [4];
	out_word_t result [4];
	logic      row_valid;
	logic      col_valid;
	logic      shift_row;
	logic      drain_col;
	logic      cnt_clear;
	logic      cnt_step;
	logic      drain_mode;
	logic      last;

	assign in_vec.w[0]  = i_data_0;
	assign in_vec.w[1]  = i_data_1;
	assign in_vec.w[2]  = i_data_2;
	assign in_vec.w[3]  = i_data_3;
	assign in_vec.w[4]  = i_data_4;
	assign in_vec.w[5]  = i_data_5;
	assign in_vec.valid = i_valid;

	// row pass, M*A.
	wino_row_transform u_row_pass (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.vin     (in_vec.dst),
		.o_res   (row_res),
		.o_valid (row_valid)
	);

	wino_tile_buffer u_tile (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_row       (row_res),
		.i_shift_row (shift_row),
		.i_drain_col (drain_col),
		.vout        (col_vec.src)
	);

	wino_seq_fsm u_fsm (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_row_valid  (row_valid),
		.i_last       (last),
		.o_shift_row  (shift_row),
		.o_drain_col  (drain_col),
		.o_cnt_clear  (cnt_clear),
		.o_cnt_step   (cnt_step),
		.o_drain_mode (drain_mode)
	);

	wino_step_counter u_cnt (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_clear      (cnt_clear),
		.i_step       (cnt_step),
		.i_drain_mode (drain_mode),
		.o_last       (last)
	);

	// column pass, A^T*(M*A).
	wino_row_transform u_col_pass (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.vin     (col_vec.dst),
		.o_res   (col_res),
		.o_valid (col_valid)
	);

	wino_output_stage u_out (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_valid  (col_valid),
		.i_res    (col_res),
		.o_result (result),
		.o_valid  (o_valid)
	);

	assign o_result_0 = result[0];
	assign o_result_1 = result[1];
	assign o_result_2 = result[2];
	assign o_result_3 = result[3];

endmodule

/* src/wino_output_stage.sv */
`timescale 1ns/1ps

module wino_output_stage import wino_types_pkg::*; (
	input  logic      clk,
	input  logic      i_rst_n,
	input  logic      i_valid,
	input  acc_t      i_res [4],
	output out_word_t o_result [4],
	output logic      o_valid
);

	acc_word_u view [4];

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			view[k].raw = i_res[k];
		end
	end

	// negative sums clamp to zero, else bits 23:8.
	always_ff @(posedge clk) begin
		for (int k = 0; k < 4; k++) begin
			o_result[k] <= view[k].fields.sign ? '0 : view[k].fields.mag;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_valid;
		end
	end

endmodule

/* src/wino_row_transform.sv */
`timescale 1ns/1ps

module wino_row_transform import wino_types_pkg::*; (
	input  logic            clk,
	input  logic            i_rst_n,
	wino_vec6_if.dst        vin,
	output acc_t            o_res [4],
	output logic            o_valid
);

	acc_t       terms [4][6];
	logic [2:0] vpipe;

	// weighted terms of each A^T row.
	always_comb begin
		terms[0] = '{vin.w[0], vin.w[1], vin.w[2], vin.w[3], vin.w[4], acc_t'(0)};
		terms[1] = '{acc_t'(0), vin.w[1], acc_t'(-vin.w[2]),
			acc_t'(vin.w[3] <<< 1), acc_t'(-(vin.w[4] <<< 1)), acc_t'(0)};
		terms[2] = '{acc_t'(0), vin.w[1], vin.w[2],
			acc_t'(vin.w[3] <<< 2), acc_t'(vin.w[4] <<< 2), acc_t'(0)};
		terms[3] = '{acc_t'(0), vin.w[1], acc_t'(-vin.w[2]),
			acc_t'(vin.w[3] <<< 3), acc_t'(-(vin.w[4] <<< 3)), vin.w[5]};
	end

	for (genvar r = 0; r < 4; r++) begin : g_row
		wino_sum_tree u_sum (
			.clk     (clk),
			.i_rst_n (i_rst_n),
			.i_d     (terms[r]),
			.o_sum   (o_res[r])
		);
	end

	// valid follows the adder latency.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			vpipe <= '0;
		end else begin
			vpipe <= {vpipe[1:0], vin.valid};
		end
	end

	assign o_valid = vpipe[2];

endmodule

/* src/wino_seq_fsm.sv */
`timescale 1ns/1ps

module wino_seq_fsm import wino_ctrl_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_row_valid,
	input  logic i_last,
	output logic o_shift_row,
	output logic o_drain_col,
	output logic o_cnt_clear,
	output logic o_cnt_step,
	output logic o_drain_mode
);

	seq_state_t state;
	seq_state_t next_state;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state  = state;
		o_shift_row = 1'b0;
		o_drain_col = 1'b0;
		case (state)
			IDLE: begin
				if (i_row_valid) begin
					o_shift_row = 1'b1;
					next_state  = LOAD;
				end
			end
			LOAD: begin
				o_shift_row = i_row_valid;
				// sixth row goes straight into drain.
				if (i_row_valid && i_last) begin
					next_state = DRAIN;
				end
			end
			DRAIN: begin
				o_drain_col = 1'b1;
				if (i_last) begin
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// counter restarts on the last step of either phase.
	assign o_cnt_step   = o_shift_row | o_drain_col;
	assign o_cnt_clear  = o_cnt_step & i_last;
	assign o_drain_mode = (state == DRAIN);

	a_no_row_in_drain: assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == DRAIN) |-> !i_row_valid);

	a_rows_contiguous: assert property (@(posedge clk) disable iff (!i_rst_n)
		(state == LOAD) |-> i_row_valid);

endmodule

/* src/wino_step_counter.sv */
`timescale 1ns/1ps

module wino_step_counter import wino_ctrl_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_clear,
	input  logic i_step,
	input  logic i_drain_mode,
	output logic o_last
);

	step_t cnt;
	step_t limit;

	assign limit  = i_drain_mode ? step_t'(DRAIN_STEPS - 1) : step_t'(LOAD_STEPS - 1);
	assign o_last = (cnt == limit);

	always_ff @(posedge clk) begin
		if (!i_rst_n || i_clear) begin
			cnt <= '0;
		end else if (i_step) begin
			cnt <= cnt + 1'b1;
		end
	end

	a_cnt_in_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		cnt <= limit);

endmodule

/* src/wino_sum_tree.sv */
`timescale 1ns/1ps

module wino_sum_tree import wino_types_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  acc_t i_d [6],
	output acc_t o_sum
);

	acc_t s1 [3];
	acc_t s2 [2];

	// three levels of pairwise adds.
	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			s1    <= '{default: '0};
			s2    <= '{default: '0};
			o_sum <= '0;
		end else begin
			s1[0] <= i_d[0] + i_d[1];
			s1[1] <= i_d[2] + i_d[3];
			s1[2] <= i_d[4] + i_d[5];
			s2[0] <= s1[0] + s1[1];
			s2[1] <= s1[2];
			o_sum <= s2[0] + s2[1];
		end
	end

endmodule

/* src/wino_tile_buffer.sv */
`timescale 1ns/1ps

module wino_tile_buffer import wino_types_pkg::*; (
	input  logic     clk,
	input  logic     i_rst_n,
	input  acc_t     i_row [4],
	input  logic     i_shift_row,
	input  logic     i_drain_col,
	wino_vec6_if.src vout
);

	// six rows of M*A, oldest row at index 0.
	acc_t tile [6][4];

	always_ff @(posedge clk) begin
		if (i_shift_row) begin
			for (int r = 0; r < 5; r++) begin
				tile[r] <= tile[r+1];
			end
			tile[5] <= i_row;
		end else if (i_drain_col) begin
			// rotate so the next column sits at index 0.
			for (int r = 0; r < 6; r++) begin
				for (int c = 0; c < 3; c++) begin
					tile[r][c] <= tile[r][c+1];
				end
				tile[r][3] <= tile[r][0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_drain_col) begin
			for (int r = 0; r < 6; r++) begin
				vout.w[r] <= tile[r][0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			vout.valid <= 1'b0;
		end else begin
			vout.valid <= i_drain_col;
		end
	end

	a_no_shift_during_drain: assert property (@(posedge clk) disable iff (!i_rst_n)
		!(i_shift_row && i_drain_col));

endmodule

/* src/wino_types_pkg.sv */
package wino_types_pkg;

	// widths of the inverse transform datapath.
	localparam int ACC_W = 30;
	localparam int OUT_W = 16;

	// accumulator word, wraps modulo 2^30.
	typedef logic signed [ACC_W-1:0] acc_t;

	// result word after clamp and extraction.
	typedef logic [OUT_W-1:0] out_word_t;

	// fixed-point view of one accumulator word.
	typedef struct packed {
		logic             sign;
		logic [4:0]       ovf;
		logic [OUT_W-1:0] mag;
		logic [7:0]       frac;
	} acc_fields_t;

	// same 30 bits, read as a sum or as fields.
	typedef union packed {
		acc_t        raw;
		acc_fields_t fields;
	} acc_word_u;

endpackage

/* src/wino_vec6_if.sv */
`timescale 1ns/1ps

interface wino_vec6_if import wino_types_pkg::*; ();

	acc_t w [6];
	logic valid;

	modport src (
		output w,
		output valid
	);

	modport dst (
		input w,
		input valid
	);

endinterface

/* tests/tb_wino_inverse.sv */
`timescale 1ns/1ps

module tb_wino_inverse import wino_types_pkg::*, wino_ctrl_pkg::*; ();

	localparam int RESET_CYCLES   = 10;
	localparam int IDLE_CYCLES    = 20;
	localparam int MIN_GAP        = 4;
	localparam int N_TILES        = 16;
	localparam int TILE_CYCLES    = 18;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES
		+ N_TILES * (TILE_CYCLES + MIN_GAP) + 100;

	// rows of A^T.
	localparam int AT [4][6] = '{
		'{1, 1, 1, 1, 1, 0},
		'{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0},
		'{0, 1, -1, 8, -8, 1}
	};

	typedef acc_t      tile_t [LOAD_STEPS][6];
	typedef out_word_t res_t [4][DRAIN_STEPS];

	logic        clk;
	logic        i_rst_n;
	logic        i_valid;
	acc_t        i_data [6];
	out_word_t   o_result_0;
	out_word_t   o_result_1;
	out_word_t   o_result_2;
	out_word_t   o_result_3;
	logic        o_valid;
	out_word_t   exp_q [$];
	logic [31:0] lfsr = 32'd95788;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	wino_inverse_top DUT (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_valid    (i_valid),
		.i_data_0   (i_data[0]),
		.i_data_1   (i_data[1]),
		.i_data_2   (i_data[2]),
		.i_data_3   (i_data[3]),
		.i_data_4   (i_data[4]),
		.i_data_5   (i_data[5]),
		.o_result_0 (o_result_0),
		.o_result_1 (o_result_1),
		.o_result_2 (o_result_2),
		.o_result_3 (o_result_3),
		.o_valid    (o_valid)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("run stopped at the cycle limit of %0d", TIMEOUT_CYCLES);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s = s >> 1;
		if (lsb) begin
			s = s ^ 32'hD000_0001;
		end
		return s;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_word(input string name, input out_word_t act, input out_word_t exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_valid(input string name, input logic act, input logic exp);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	// Y = A^T * M * A wrapped to 30 bits and clamped through bits 23:8.
	task automatic compute_ref(input tile_t m, output res_t y);
		acc_t      t [LOAD_STEPS][4];
		acc_t      sum;
		acc_word_u u;
		for (int i = 0; i < LOAD_STEPS; i++) begin
			for (int k = 0; k < 4; k++) begin
				sum = '0;
				for (int j = 0; j < 6; j++) begin
					sum = sum + acc_t'(m[i][j] * AT[k][j]);
				end
				t[i][k] = sum;
			end
		end
		for (int k = 0; k < 4; k++) begin
			for (int c = 0; c < DRAIN_STEPS; c++) begin
				sum = '0;
				for (int i = 0; i < LOAD_STEPS; i++) begin
					sum = sum + acc_t'(t[i][c] * AT[k][i]);
				end
				u.raw = sum;
				y[k][c] = u.fields.sign ? '0 : u.fields.mag;
			end
		end
	endtask

	// four words per column in output order.
	task automatic push_expected(input res_t y);
		for (int c = 0; c < DRAIN_STEPS; c++) begin
			for (int k = 0; k < 4; k++) begin
				exp_q.push_back(y[k][c]);
			end
		end
	endtask

	task automatic send_tile(input tile_t m);
		for (int r = 0; r < LOAD_STEPS; r++) begin
			@(negedge clk);
			i_valid = 1'b1;
			for (int k = 0; k < 6; k++) begin
				i_data[k] = m[r][k];
			end
		end
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	task automatic rand_tile(output tile_t m);
		logic [31:0] b;
		foreach (m[i, j]) begin
			take_bits(20, b);
			m[i][j] = acc_t'($signed(b[19:0]));
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
	endtask

	// one expected column per o_valid cycle.
	always @(negedge clk) begin
		if (o_valid === 1'b1) begin
			if (exp_q.size() < 4) begin
				errors++;
				$display("o_valid high at %0t with no column expected", $time);
			end else begin
				check_word("o_result_0", o_result_0, exp_q.pop_front());
				check_word("o_result_1", o_result_1, exp_q.pop_front());
				check_word("o_result_2", o_result_2, exp_q.pop_front());
				check_word("o_result_3", o_result_3, exp_q.pop_front());
			end
		end
	end

	task automatic idle_after_reset();
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_valid("o_valid", o_valid, 1'b0);
		end
	endtask

	task automatic single_tile_timing();
		tile_t m;
		res_t  y;
		foreach (m[i, j]) begin
			m[i][j] = acc_t'((i * 6 + j + 1) * 256);
		end
		compute_ref(m, y);
		push_expected(y);
		send_tile(m);
		// output due 14 to 17 cycles after row 0.
		for (int n = 7; n <= 19; n++) begin
			@(negedge clk);
			check_valid("o_valid", o_valid, n >= 14 && n <= 17);
		end
		wait_drain();
	endtask

	task automatic clamp_and_overflow();
		tile_t m;
		res_t  y;
		foreach (m[i, j]) begin
			m[i][j] = acc_t'(-768);
		end
		compute_ref(m, y);
		push_expected(y);
		send_tile(m);
		wait_drain();
		for (int p = 0; p < 2; p++) begin
			foreach (m[i, j]) begin
				m[i][j] = '0;
			end
			// with only m[1][1] set every Y word equals it.
			m[1][1] = (p == 0) ? acc_t'(30'h1F12_3456) : acc_t'(30'h0512_3456);
			foreach (y[k, c]) begin
				y[k][c] = 16'h1234;
			end
			push_expected(y);
			send_tile(m);
			wait_drain();
		end
	endtask

	task automatic random_tiles();
		tile_t m;
		res_t  y;
		for (int t = 0; t < 10; t++) begin
			rand_tile(m);
			compute_ref(m, y);
			push_expected(y);
			send_tile(m);
			wait_drain();
		end
	endtask

	task automatic back_to_back_tiles();
		tile_t m_a;
		tile_t m_b;
		res_t  y;
		rand_tile(m_a);
		rand_tile(m_b);
		compute_ref(m_a, y);
		push_expected(y);
		compute_ref(m_b, y);
		push_expected(y);
		send_tile(m_a);
		repeat (MIN_GAP - 1) @(negedge clk);
		send_tile(m_b);
		wait_drain();
	endtask

	initial begin
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		for (int k = 0; k < 6; k++) begin
			i_data[k] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		i_rst_n = 1'b1;
		idle_after_reset();
		single_tile_timing();
		clamp_and_overflow();
		random_tiles();
		back_to_back_tiles();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
